// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into a log, then look for the pass line
rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module fpCvtTb -o fpCvtTbSim &&
    ./obj_dir/fpCvtTbSim > sim.log 2>&1 ||
    echo "build or simulation stopped with an error"

test -f sim.log && cat sim.log

grep -q "RESULT: PASS" sim.log && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// ==== sim/fpCvtTb.sv ====
`timescale 1ns/100ps
`include "fpConsts.svh"

module fpCvtTb;
    import fpTypesPkg::*;
    import wbBusPkg::*;

    localparam int ACK_LIMIT  = 16;
    localparam int DONE_LIMIT = 8;
    localparam int RAND_COUNT = 300;

    logic    clk = 1'b0;
    logic    arstN;
    logic    cyc;
    logic    stb;
    logic    we;
    wbAdrT   adr;
    wbDatT   datW;
    wbSelT   sel;
    wbDatT   datR;
    logic    ack;

    // random source state
    logic [31:0] lfsr;

    // directed single to double vectors and hand computed doubles
    float32T s2dIn [9] = '{32'h00000000, 32'h80000000, 32'h7F800000, 32'hFF800000,
                           32'h7FC12345, 32'h00000001, 32'h007FFFFF, 32'h3F800000,
                           32'h7F7FFFFF};
    float64T s2dExp [9] = '{64'h0000000000000000, 64'h8000000000000000,
                            64'h7FF0000000000000, 64'hFFF0000000000000,
                            64'h7FF82468A0000000, 64'h36A0000000000000,
                            64'h380FFFFFC0000000, 64'h3FF0000000000000,
                            64'h47EFFFFFE0000000};

    // directed double to single with flag pairs {overflow, inexact}
    float64T d2sIn [13] = '{64'h3FF0000000000000, 64'hC004000000000000,
                            64'h3FF0000010000000, 64'h3FF0000030000000,
                            64'h3FFFFFFFF0000000, 64'h47F0000000000000,
                            64'hC7EFFFFFF0000000, 64'h36A0000000000000,
                            64'h36A8000000000000, 64'h3680000000000000,
                            64'hB680000000000000, 64'h7FF0000000000001,
                            64'hFFF0000000000000};
    float32T d2sExp [13] = '{32'h3F800000, 32'hC0200000, 32'h3F800000, 32'h3F800002,
                             32'h40000000, 32'h7F800000, 32'hFF800000, 32'h00000001,
                             32'h00000002, 32'h00000000, 32'h80000000, 32'h7FC00000,
                             32'hFF800000};
    logic [1:0] d2sFlg [13] = '{2'b00, 2'b00, 2'b01, 2'b01, 2'b01, 2'b11, 2'b11,
                                2'b00, 2'b01, 2'b01, 2'b01, 2'b00, 2'b00};

    fpCvtTop dut_i (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .sel   (sel),
        .datR  (datR),
        .ack   (ack)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    // ====================================================================
    // failure reporting and compare tasks
    // ====================================================================
    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        abortRun($sformatf("[FAIL] time %0t: %s", $time, msg));
    endtask

    task automatic checkFloat64(input float64T got, input float64T exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s: got %h expected %h", what, got, exp));
        end
    endtask

    task automatic checkFloat32(input float32T got, input float32T exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s: got %h expected %h", what, got, exp));
        end
    endtask

    // compares the whole STATUS word including busy and done
    task automatic checkFlags(input wbDatT got, input wbDatT exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s: STATUS %h expected %h", what, got, exp));
        end
    endtask

    // status after a finished conversion has busy low and done high
    function automatic wbDatT doneStatus(input logic inx, input logic ovf);
        return {28'd0, ovf, inx, 1'b1, 1'b0};
    endfunction

    // ====================================================================
    // random bits
    // ====================================================================
    // right shifting form with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic takeBits(input int n, output logic [63:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsrStep(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // ====================================================================
    // reference models from the format rules
    // ====================================================================
    function automatic float64T refS2d(input float32T a);
        logic        s;
        int          e;
        logic [22:0] m;
        int          p;
        logic [51:0] f;
        s = a[31];
        e = int'(a[30:23]);
        m = a[22:0];
        if (e == 0 && m == 0) begin
            return {s, 63'd0};
        end
        if (e == 255) begin
            return {s, 11'h7FF, m, 29'd0};
        end
        if (e != 0) begin
            return {s, 11'(e + 896), m, 29'd0};
        end
        // denormal is m * 2^-149 with its leading one at bit p
        p = 0;
        for (int k = 0; k < 23; k++) begin
            if (m[k]) begin
                p = k;
            end
        end
        f = {m, 29'd0};
        // leading one falls off the top and the rest becomes the fraction
        f = f << (23 - p);
        return {s, 11'(p + 874), f};
    endfunction

    function automatic float32T refD2s(input float64T a, output logic inx, output logic ovf);
        logic        s;
        int          e;
        logic [51:0] m;
        logic [52:0] sig;
        int          ex;
        int          sh;
        logic [63:0] q;
        logic [63:0] rem;
        logic [63:0] half;
        s   = a[63];
        e   = int'(a[62:52]);
        m   = a[51:0];
        inx = 1'b0;
        ovf = 1'b0;
        if (e == 2047) begin
            if (m != 0) begin
                return {s, 8'hFF, 1'b1, m[50:29]};
            end
            return {s, 8'hFF, 23'd0};
        end
        if (e == 0 && m == 0) begin
            return {s, 31'd0};
        end
        sig = {e != 0, m};
        if (e == 0) begin
            e = 1;
        end
        ex = e - 896;
        // normal keeps 24 significant bits and a denormal fewer
        sh = (ex >= 1) ? 29 : 30 - ex;
        if (sh > 60) begin
            sh = 60;
        end
        q    = 64'(sig) >> sh;
        rem  = 64'(sig) & ((64'd1 << sh) - 64'd1);
        half = 64'd1 << (sh - 1);
        inx  = rem != 0;
        // round to nearest with ties to even
        if (rem > half || (rem == half && q[0])) begin
            q = q + 64'd1;
        end
        if (ex < 1) begin
            // 2^23 after rounding reads as the smallest normal
            return {s, 31'(q)};
        end
        if (q[24]) begin
            ex = ex + 1;
            q  = q >> 1;
        end
        if (ex >= 255) begin
            ovf = 1'b1;
            inx = 1'b1;
            return {s, 8'hFF, 23'd0};
        end
        return {s, 8'(ex), q[22:0]};
    endfunction

    // ====================================================================
    // bus access
    // ====================================================================
    task automatic busCycle(input logic w, input wbAdrT a, input wbDatT d, output wbDatT q);
        int n;
        @(negedge clk);
        if (ack) begin
            reportMismatch("ack high before a new access");
        end
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = w;
        adr  = a;
        datW = d;
        sel  = 4'hF;
        n    = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > ACK_LIMIT) begin
                abortRun($sformatf("timeout waiting for ack at address %0d", a));
            end
        end while (!ack);
        if (n != 1) begin
            reportMismatch($sformatf("ack came %0d cycles after stb", n));
        end
        // datR follows adr which is still held here
        q    = datR;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        sel  = 4'h0;
    endtask

    task automatic wbWrite(input wbAdrT a, input wbDatT d);
        wbDatT unused;
        busCycle(1'b1, a, d, unused);
    endtask

    task automatic wbRead(input wbAdrT a, output wbDatT d);
        busCycle(1'b0, a, 32'd0, d);
    endtask

    task automatic waitDone(output wbDatT st);
        int n;
        n = 0;
        do begin
            wbRead(`REG_STATUS, st);
            n++;
            if (n > DONE_LIMIT) begin
                abortRun("timeout waiting for the done bit in STATUS");
            end
        end while (!st[1]);
    endtask

    task automatic convertS2d(input float32T a, output float64T r, output wbDatT st);
        wbDatT lo;
        wbDatT hi;
        wbWrite(`REG_OP_LO, a);
        wbWrite(`REG_CTRL, 32'd0);
        waitDone(st);
        wbRead(`REG_RES_LO, lo);
        wbRead(`REG_RES_HI, hi);
        r = {hi, lo};
    endtask

    task automatic convertD2s(input float64T a, output float32T r, output wbDatT st);
        wbDatT lo;
        wbDatT hi;
        wbWrite(`REG_OP_LO, a[31:0]);
        wbWrite(`REG_OP_HI, a[63:32]);
        wbWrite(`REG_CTRL, 32'd1);
        waitDone(st);
        wbRead(`REG_RES_LO, lo);
        wbRead(`REG_RES_HI, hi);
        // single result sits in the low word only
        checkFloat32(hi, 32'd0, "d2s high result word");
        r = lo;
    endtask

    task automatic testS2d(input float32T a, input float64T exp);
        float64T r;
        wbDatT   st;
        convertS2d(a, r, st);
        checkFloat64(r, exp, $sformatf("s2d of %h", a));
        checkFlags(st, doneStatus(1'b0, 1'b0), $sformatf("s2d of %h", a));
    endtask

    task automatic testD2s(input float64T a, input float32T exp, input logic inx,
                           input logic ovf);
        float32T r;
        wbDatT   st;
        convertD2s(a, r, st);
        checkFloat32(r, exp, $sformatf("d2s of %h", a));
        checkFlags(st, doneStatus(inx, ovf), $sformatf("d2s of %h", a));
    endtask

    // ====================================================================
    // scenario sequence
    // ====================================================================
    initial begin
        wbDatT       w;
        wbDatT       hi;
        logic [63:0] r;
        float32T     x;
        float32T     xBack;
        float32T     y;
        float64T     d;
        logic        inxE;
        logic        ovfE;
        logic [10:0] e;
        logic [51:0] m;
        arstN = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datW  = '0;
        sel   = '0;
        lfsr  = 32'h4ab4ce57;
        repeat (4) @(negedge clk);
        arstN = 1'b1;

        // registers read zero out of reset
        wbRead(`REG_STATUS, w);
        checkFlags(w, 32'd0, "STATUS after reset");
        wbRead(`REG_RES_LO, w);
        wbRead(`REG_RES_HI, hi);
        checkFloat64({hi, w}, 64'd0, "result after reset");

        foreach (s2dIn[k]) begin
            testS2d(s2dIn[k], s2dExp[k]);
        end
        foreach (d2sIn[k]) begin
            testD2s(d2sIn[k], d2sExp[k], d2sFlg[k][0], d2sFlg[k][1]);
        end

        // random singles widened then narrowed back
        for (int n = 0; n < RAND_COUNT; n++) begin
            takeBits(32, r);
            x = r[31:0];
            testS2d(x, refS2d(x));
            // a signalling NaN comes back quiet
            xBack = x;
            if (&x[30:23] && |x[22:0]) begin
                xBack[22] = 1'b1;
            end
            testD2s(refS2d(x), xBack, 1'b0, 1'b0);
        end

        // random doubles with exponents around the single range
        for (int n = 0; n < RAND_COUNT; n++) begin
            takeBits(9, r);
            e = 11'(840 + (int'(r[8:0]) % 330));
            takeBits(4, r);
            if (r[3:0] == 4'd0) begin
                e = 11'd0;
            end else if (r[3:0] == 4'd1) begin
                e = 11'h7FF;
            end
            takeBits(52, r);
            m = r[51:0];
            // cleared low bits make exact ties likely
            takeBits(2, r);
            if (r[1:0] == 2'd0) begin
                m[27:0] = '0;
            end
            takeBits(1, r);
            d = {r[0], e, m};
            y = refD2s(d, inxE, ovfE);
            testD2s(d, y, inxE, ovfE);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/cntlz24.sv ====
`timescale 1ns/100ps

// leading zero count of a 24 bit vector
// first pick the leading nonzero nibble, then the bit inside it
module cntlz24 (
    input  logic [23:0]         i,
    output fpTypesPkg::lzCountT o
);
    import fpTypesPkg::*;

    logic [3:0] nibs [6];
    logic [2:0] nibIdx;
    logic [3:0] nib;
    logic [1:0] bitIdx;

    always_comb begin
        // nibble 0 is the most significant
        for (int k = 0; k < 6; k++) begin
            nibs[k] = i[23 - 4*k -: 4];
        end

        // walk from the bottom so the highest nonzero nibble wins
        nibIdx = 3'd5;
        for (int k = 5; k >= 0; k--) begin
            if (|nibs[k]) begin
                nibIdx = 3'(k);
            end
        end

        // position inside the chosen nibble
        nib = nibs[nibIdx];
        casez (nib)
            4'b1???: bitIdx = 2'd0;
            4'b01??: bitIdx = 2'd1;
            4'b001?: bitIdx = 2'd2;
            default: bitIdx = 2'd3;
        endcase

        // nibble index times four plus bit index
        o = lzCountT'({nibIdx, bitIdx});
    end

endmodule

// ==== source/fd2s.sv ====
`timescale 1ns/100ps
`include "fpConsts.svh"

// double to single, round to nearest even
module fd2s (
    input  fpTypesPkg::float64T a,
    output fpTypesPkg::float32T o,
    output logic                inexact,
    output logic                overflow
);
    import fpTypesPkg::*;

    localparam int REBIAS = `DBL_BIAS - `SGL_BIAS;
    localparam int DROP   = `DBL_MAN_BITS - `SGL_MAN_BITS;

    logic               signI;
    dblExpT             expI;
    dblManT             manI;
    logic               xinf;
    logic               xz;
    logic               vz;

    // rebiased exponent, signed so underflow shows as <= 0
    dblExpT             expEff;
    logic signed [12:0] expR;

    // normal path
    sglManT             manT;
    logic               grd;
    logic               stk;
    logic               rndUp;
    logic [23:0]        manRnd;
    logic signed [12:0] expN;

    // denormal path
    logic [52:0]        sig;
    logic [5:0]         shAmt;
    logic [52:0]        sigSh;
    logic [52:0]        lostMask;
    logic               dGrd;
    logic               dStk;
    logic               dRnd;
    logic [23:0]        dMan;

    fpDecomp #(.WID(`DBL_WIDTH)) decomp_i (
        .i    (a),
        .sgn  (signI),
        .exp  (expI),
        .man  (manI),
        .xinf (xinf),
        .xz   (xz),
        .vz   (vz)
    );

    // ====================================================================
    // rebias and rounding for both paths
    // ====================================================================
    always_comb begin
        // double denormal acts as exponent 1, far below single range
        expEff = xz ? dblExpT'(1) : expI;
        expR   = $signed({2'b00, expEff}) - 13'(REBIAS);

        // keep 23 bits, next bit is guard, rest folds into sticky
        manT   = manI[`DBL_MAN_BITS-1 -: `SGL_MAN_BITS];
        grd    = manI[DROP-1];
        stk    = |manI[DROP-2:0];
        rndUp  = grd & (stk | manT[0]);
        manRnd = {1'b0, manT} + 24'(rndUp);
        // mantissa carry bumps the exponent, field wraps to zero
        expN   = expR + $signed({12'd0, manRnd[23]});

        // hidden one back in before shifting right
        sig = {1'b1, manI};
        // shift by 29-expR leaves guard at bit 0 and the field above it
        if (expR < -13'sd30) begin
            shAmt = 6'd60;
        end else begin
            shAmt = 6'(13'sd29 - expR);
        end
        sigSh    = sig >> shAmt;
        lostMask = ~({53{1'b1}} << shAmt);
        dGrd     = sigSh[0];
        dStk     = |(sig & lostMask);
        dRnd     = dGrd & (dStk | sigSh[1]);
        // a carry here lands on exponent 1, the smallest normal
        dMan     = {1'b0, sigSh[23:1]} + 24'(dRnd);
    end

    // ====================================================================
    // result select
    // ====================================================================
    always_comb begin
        inexact  = 1'b0;
        overflow = 1'b0;
        if (xinf) begin
            if (|manI) begin
                // NaN, top payload bits with the quiet bit forced
                o = {signI, sglExpT'('1), 1'b1, manI[`DBL_MAN_BITS-2 -: `SGL_MAN_BITS-1]};
            end else begin
                o = {signI, sglExpT'('1), sglManT'(0)};
            end
        end else if (vz) begin
            o = {signI, 31'd0};
        end else if (expR >= 13'sd1) begin
            if (expN >= 13'sd255) begin
                // too large, infinity with both flags
                o        = {signI, sglExpT'('1), sglManT'(0)};
                overflow = 1'b1;
                inexact  = 1'b1;
            end else begin
                o       = {signI, sglExpT'(expN[7:0]), manRnd[22:0]};
                inexact = grd | stk;
            end
        end else begin
            // denormal or zero, exponent field is just the carry
            o       = {signI, 7'd0, dMan};
            inexact = dGrd | dStk;
        end
    end

endmodule

// ==== source/fpConsts.svh ====
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

// ====================================================================
// float formats
// ====================================================================

// whole word widths
`define SGL_WIDTH     32
`define DBL_WIDTH     64

// exponent field widths
`define SGL_EXP_BITS  8
`define DBL_EXP_BITS  11

// stored mantissa widths, hidden one not counted
`define SGL_MAN_BITS  23
`define DBL_MAN_BITS  52

// exponent biases
`define SGL_BIAS      127
`define DBL_BIAS      1023

// ====================================================================
// register map, word addresses
// ====================================================================
`define REG_OP_LO     3'd0
`define REG_OP_HI     3'd1
`define REG_CTRL      3'd2
`define REG_RES_LO    3'd3
`define REG_RES_HI    3'd4
`define REG_STATUS    3'd5

`endif

// ==== source/fpCvtRegs.sv ====
`timescale 1ns/100ps
`include "fpConsts.svh"

// Wishbone classic register block of the converter
module fpCvtRegs (
    input  logic                clk,
    input  logic                arstN,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  wbBusPkg::wbAdrT     adr,
    input  wbBusPkg::wbDatT     datW,
    input  wbBusPkg::wbSelT     sel,
    output wbBusPkg::wbDatT     datR,
    output logic                ack,
    output fpTypesPkg::float32T opSgl,
    output fpTypesPkg::float64T opDbl,
    input  fpTypesPkg::float64T resS2d,
    input  fpTypesPkg::float32T resD2s,
    input  logic                inexact,
    input  logic                overflow
);
    import fpTypesPkg::*;
    import wbBusPkg::*;

    wbDatT    opLo;
    wbDatT    opHi;
    logic     dirD2s;
    float64T  res;
    logic     busy;
    logic     done;
    logic     flagInexact;
    logic     flagOverflow;
    cvtStateT state;
    logic     access;
    logic     wrEn;
    logic     ctrlWr;

    // byte lane merge for partial writes
    function automatic wbDatT mergeBytes(input wbDatT old, input wbDatT din, input wbSelT be);
        wbDatT m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                m[8*b +: 8] = din[8*b +: 8];
            end
        end
        return m;
    endfunction

    // ====================================================================
    // bus handshake
    // ====================================================================

    // new access only while ack is low, so ack never lasts two cycles
    assign access = cyc & stb & ~ack;
    assign wrEn   = access & we;
    assign ctrlWr = wrEn & (adr == `REG_CTRL);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // operand and direction writes land on the acking edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opLo   <= '0;
            opHi   <= '0;
            dirD2s <= 1'b0;
        end else if (wrEn) begin
            if (adr == `REG_OP_LO) begin
                opLo <= mergeBytes(opLo, datW, sel);
            end
            if (adr == `REG_OP_HI) begin
                opHi <= mergeBytes(opHi, datW, sel);
            end
            if (adr == `REG_CTRL && sel[0]) begin
                dirD2s <= datW[0];
            end
        end
    end

    // ====================================================================
    // launch machine
    // ====================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state        <= cvtIdle;
            busy         <= 1'b0;
            done         <= 1'b0;
            res          <= '0;
            flagInexact  <= 1'b0;
            flagOverflow <= 1'b0;
        end else begin
            case (state)
                cvtIdle: begin
                    if (ctrlWr) begin
                        state <= cvtLatch;
                        busy  <= 1'b1;
                        done  <= 1'b0;
                    end
                end
                cvtLatch: begin
                    // operands settled one edge ago, converters are combinational
                    if (dirD2s) begin
                        res          <= {32'd0, resD2s};
                        flagInexact  <= inexact;
                        flagOverflow <= overflow;
                    end else begin
                        // widening is exact
                        res          <= resS2d;
                        flagInexact  <= 1'b0;
                        flagOverflow <= 1'b0;
                    end
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= cvtIdle;
                end
                default: state <= cvtIdle;
            endcase
        end
    end

    // read mux, whole words regardless of sel
    always_comb begin
        case (adr)
            `REG_OP_LO:  datR = opLo;
            `REG_OP_HI:  datR = opHi;
            `REG_CTRL:   datR = {31'd0, dirD2s};
            `REG_RES_LO: datR = res[31:0];
            `REG_RES_HI: datR = res[63:32];
            `REG_STATUS: datR = {28'd0, flagOverflow, flagInexact, done, busy};
            default:     datR = '0;
        endcase
    end

    // single operand is the low word, double is both joined
    assign opSgl = opLo;
    assign opDbl = {opHi, opLo};

endmodule

// ==== source/fpCvtTop.sv ====
`timescale 1ns/100ps

// float precision converter on a Wishbone classic slave port
module fpCvtTop (
    input  logic            clk,
    input  logic            arstN,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  wbBusPkg::wbAdrT adr,
    input  wbBusPkg::wbDatT datW,
    input  wbBusPkg::wbSelT sel,
    output wbBusPkg::wbDatT datR,
    output logic            ack
);
    import fpTypesPkg::*;

    // operand nets out of the register block
    float32T opSgl;
    float64T opDbl;

    // converter results back into it
    float64T resS2d;
    float32T resD2s;
    logic    inexact;
    logic    overflow;

    fpCvtRegs regs_i (
        .clk      (clk),
        .arstN    (arstN),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datW     (datW),
        .sel      (sel),
        .datR     (datR),
        .ack      (ack),
        .opSgl    (opSgl),
        .opDbl    (opDbl),
        .resS2d   (resS2d),
        .resD2s   (resD2s),
        .inexact  (inexact),
        .overflow (overflow)
    );

    // both converters run all the time, the register block picks one
    fs2d s2d_i (
        .a (opSgl),
        .o (resS2d)
    );

    fd2s d2s_i (
        .a        (opDbl),
        .o        (resD2s),
        .inexact  (inexact),
        .overflow (overflow)
    );

endmodule

// ==== source/fpDecomp.sv ====
`timescale 1ns/100ps
`include "fpConsts.svh"

// field split for single or double words
// the exponent width follows from the word width
module fpDecomp #(
    parameter int WID = `SGL_WIDTH,
    localparam int EXPW = (WID == `DBL_WIDTH) ? `DBL_EXP_BITS : `SGL_EXP_BITS,
    localparam int MANW = WID - EXPW - 1
) (
    input  logic [WID-1:0]  i,
    output logic            sgn,
    output logic [EXPW-1:0] exp,
    output logic [MANW-1:0] man,
    output logic            xinf,
    output logic            xz,
    output logic            vz
);

    // sign is the top bit
    assign sgn = i[WID-1];

    // exponent sits right under the sign
    assign exp = i[WID-2 -: EXPW];

    // stored mantissa in the low bits
    assign man = i[MANW-1:0];

    // all ones exponent: infinity or NaN
    assign xinf = &exp;

    // zero exponent: zero or denormal
    assign xz = ~|exp;

    // magnitude zero, sign ignored so -0 counts
    assign vz = ~|i[WID-2:0];

endmodule

// ==== source/fpTypesPkg.sv ====
`include "fpConsts.svh"

package fpTypesPkg;

    // whole packed floats
    typedef logic [`SGL_WIDTH-1:0] float32T;
    typedef logic [`DBL_WIDTH-1:0] float64T;

    // exponent fields
    typedef logic [`SGL_EXP_BITS-1:0] sglExpT;
    typedef logic [`DBL_EXP_BITS-1:0] dblExpT;

    // mantissa fields without the hidden bit
    typedef logic [`SGL_MAN_BITS-1:0] sglManT;
    typedef logic [`DBL_MAN_BITS-1:0] dblManT;

    // leading zero count over a single mantissa plus one bit
    typedef logic [4:0] lzCountT;

    // launch machine of the register block
    // idle waits for a CTRL write, latch captures the converter output
    typedef enum logic {
        cvtIdle,
        cvtLatch
    } cvtStateT;

endpackage

// ==== source/fs2d.sv ====
`timescale 1ns/100ps
`include "fpConsts.svh"

// single to double, every single is exactly representable
module fs2d (
    input  fpTypesPkg::float32T a,
    output fpTypesPkg::float64T o
);
    import fpTypesPkg::*;

    localparam int REBIAS  = `DBL_BIAS - `SGL_BIAS;
    localparam int MAN_PAD = `DBL_MAN_BITS - `SGL_MAN_BITS;

    logic    signI;
    sglExpT  expI;
    sglManT  manI;
    logic    xinf;
    logic    xz;
    logic    vz;
    lzCountT lz;
    dblExpT  expO;
    dblManT  manO;

    fpDecomp #(.WID(`SGL_WIDTH)) decomp_i (
        .i    (a),
        .sgn  (signI),
        .exp  (expI),
        .man  (manI),
        .xinf (xinf),
        .xz   (xz),
        .vz   (vz)
    );

    // low one keeps the count below 24 even for the smallest denormal
    cntlz24 lzc_i (
        .i ({manI, 1'b1}),
        .o (lz)
    );

    always_comb begin
        if (vz) begin
            // signed zero stays signed zero
            expO = '0;
            manO = '0;
        end else if (xinf) begin
            // inf or NaN, payload moves to the top
            expO = '1;
            manO = {manI, MAN_PAD'(0)};
        end else if (xz) begin
            // denormal: leading one at bit 22-lz weighs 2^(-127-lz)
            // shift one past the leading one to hide it
            expO = dblExpT'(REBIAS) - dblExpT'(lz);
            manO = {manI << (lz + 1'b1), MAN_PAD'(0)};
        end else begin
            // plain rebias, mantissa copied
            expO = dblExpT'(expI) + dblExpT'(REBIAS);
            manO = {manI, MAN_PAD'(0)};
        end
    end

    assign o = {signI, expO, manO};

endmodule

// ==== source/wbBusPkg.sv ====
package wbBusPkg;

    // word address, six registers used out of eight
    typedef logic [2:0] wbAdrT;

    // data bus, both directions
    typedef logic [31:0] wbDatT;

    // byte lane selects, one per data byte
    typedef logic [3:0] wbSelT;

endpackage

// ==== tb.f ====
+incdir+source
source/fpTypesPkg.sv
source/wbBusPkg.sv
source/fpDecomp.sv
source/cntlz24.sv
source/fs2d.sv
source/fd2s.sv
source/fpCvtRegs.sv
source/fpCvtTop.sv
sim/fpCvtTb.sv
